// File: Makefile
# Verilator build and run for the pipelined ALU testbench

VERILATOR ?= verilator
TOP       ?= tb_alu
RTL_TOP   ?= alu_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= NO ERRORS

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the run passes only when the pass line shows up in the output
run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: alu_decode.sv
`timescale 1ns/10ps
`default_nettype none

module alu_decode import riscv_isa_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cyc,
    input  logic            stb,
    input  logic            ack,
    input  logic [6:0]      opcode,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    input  logic [XLEN-1:0] r1,
    input  logic [XLEN-1:0] r2,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] pc,
    output logic            go,
    output alu_op_e         op,
    output logic [XLEN-1:0] a,
    output logic [XLEN-1:0] b,
    output logic [XLEN-1:0] imm_q,
    output logic [XLEN-1:0] pc_q
);

    logic    busy;
    logic    accept;
    alu_op_e dec_op;

    assign accept = cyc & stb & ~busy;       // a held stb is ignored until ack

    always_comb begin
        dec_op = op_none;
        case (opcode)
            OP: begin
                if (funct3 == F3_ADD && funct7 == F7_SUB)
                    dec_op = op_sub;
                else if (funct3 == F3_SLT && funct7 == F7_BASE)
                    dec_op = op_slt;
                else if (funct3 == F3_SRL && funct7 == F7_BASE)
                    dec_op = op_srl;
            end
            OP_IMM: if (funct3 == F3_ADD) dec_op = op_addi;
            LOAD, STORE: if (funct3 == F3_SLT) dec_op = op_addr;  // word access only
            BRANCH: begin
                if (funct3 == F3_ADD)
                    dec_op = op_beq;
                else if (funct3 == F3_BLT)
                    dec_op = op_blt;
            end
            JALR: if (funct3 == F3_ADD) dec_op = op_jalr;
            AUIPC: dec_op = op_auipc;        // no function field
            OP_FP: begin
                if (funct3 == F3_ADD && funct7 == F7_FMUL)
                    dec_op = op_fmul;
                else if (funct3 == F3_FCLASS && funct7 == F7_FCLASS)
                    dec_op = op_fclass;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            go   <= 1'b0;
            op   <= op_none;
        end else begin
            go <= accept;                    // single pulse per transaction
            if (accept) begin
                busy <= 1'b1;
                op   <= dec_op;
            end else if (ack) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            a     <= r1;
            b     <= r2;
            imm_q <= imm;
            pc_q  <= pc;
        end
    end

endmodule

`default_nettype wire

// File: alu_fp_unit.sv
`timescale 1ns/10ps
`default_nettype none

module alu_fp_unit import riscv_isa_pkg::*, fp32_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            go,
    input  alu_op_e         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic            done,
    output logic [XLEN-1:0] fp_result,
    output logic            nan_inf,
    output logic            range_err
);

    logic [EXP_W-1:0]        ex_a;
    logic [EXP_W-1:0]        ex_b;
    logic [EXP_W-1:0]        eff_a;
    logic [EXP_W-1:0]        eff_b;
    logic                    a_zero;
    logic                    b_zero;
    logic                    a_special;
    logic                    b_special;
    logic                    sign_p;
    logic [MAN_W:0]          sig_a;
    logic [MAN_W:0]          sig_b;
    logic [2*MAN_W+1:0]      prod;
    logic [2*MAN_W+1:0]      norm;
    logic [5:0]              lz;
    logic signed [EXP_W+1:0] exp_n;
    logic signed [EXP_W+1:0] exp_f;
    logic                    lsb;
    logic                    guard;
    logic                    rnd;
    logic                    sticky;
    logic [MAN_W:0]          man_r;
    logic [XLEN-1:0]         mul_res;
    logic [XLEN-1:0]         cls_res;
    int                      cls_idx;
    logic [XLEN-1:0]         res_d;
    logic                    range_d;
    logic                    own;

    assign ex_a      = a[MAN_W +: EXP_W];
    assign ex_b      = b[MAN_W +: EXP_W];
    assign a_zero    = (a[XLEN-2:0] == '0);
    assign b_zero    = (b[XLEN-2:0] == '0);
    assign a_special = (ex_a == EXP_MAX);    // infinity or nan
    assign b_special = (ex_b == EXP_MAX);
    assign sign_p    = a[XLEN-1] ^ b[XLEN-1];

    // subnormals take exponent 1 and no hidden bit
    assign eff_a = (ex_a == '0) ? EXP_W'(1) : ex_a;
    assign eff_b = (ex_b == '0) ? EXP_W'(1) : ex_b;
    assign sig_a = {(ex_a != '0), a[MAN_W-1:0]};
    assign sig_b = {(ex_b != '0), b[MAN_W-1:0]};
    assign prod  = sig_a * sig_b;            // two integer bits on top

    always_comb begin
        lz = '0;
        for (int i = 0; i <= 2*MAN_W+1; i++) begin
            if (prod[i])
                lz = 6'(2*MAN_W + 1 - i);    // highest set bit wins
        end
    end

    // lz of 0 is the one-bit right shift case, larger lz shifts left
    assign norm  = prod << lz;
    assign exp_n = (EXP_W+2)'(int'(eff_a) + int'(eff_b) - EXP_BIAS + 1 - int'(lz));

    assign lsb    = norm[MAN_W+1];
    assign guard  = norm[MAN_W];
    assign rnd    = norm[MAN_W-1];
    assign sticky = |norm[MAN_W-2:0];
    assign man_r  = {1'b0, norm[2*MAN_W:MAN_W+1]} + (MAN_W+1)'(guard & (rnd | sticky | lsb));
    assign exp_f  = exp_n + (EXP_W+2)'(man_r[MAN_W]);    // rounding carry

    always_comb begin
        if (a_zero || b_zero)
            mul_res = '0;                    // zero short-cut gives +0
        else if (exp_f >= EXP_MAX)
            mul_res = {sign_p, EXP_W'(EXP_MAX), {MAN_W{1'b0}}};
        else if (exp_f < 1)
            mul_res = {sign_p, {EXP_W{1'b0}}, {MAN_W{1'b0}}};  // flush
        else
            mul_res = {sign_p, exp_f[EXP_W-1:0], man_r[MAN_W-1:0]};
    end

    always_comb begin
        if (a_special && a[MAN_W-1:0] == '0)
            cls_idx = a[XLEN-1] ? CLS_NEG_INF : CLS_POS_INF;
        else if (a_special)
            cls_idx = a[MAN_W-1] ? CLS_QNAN : CLS_SNAN;
        else if (a_zero)
            cls_idx = a[XLEN-1] ? CLS_NEG_ZERO : CLS_POS_ZERO;
        else if (ex_a == '0)
            cls_idx = a[XLEN-1] ? CLS_NEG_SUB : CLS_POS_SUB;
        else
            cls_idx = a[XLEN-1] ? CLS_NEG_NORM : CLS_POS_NORM;
        cls_res          = '0;
        cls_res[cls_idx] = 1'b1;             // one-hot class word
    end

    assign own = (op == op_fmul) || (op == op_fclass);

    always_comb begin
        res_d   = '0;
        range_d = 1'b0;
        case (op)
            op_fmul: begin
                res_d   = mul_res;
                range_d = (mul_res[MAN_W +: EXP_W] == '0) ||
                          (mul_res[MAN_W +: EXP_W] == EXP_MAX);
            end
            op_fclass: res_d = cls_res;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done      <= 1'b0;
            nan_inf   <= 1'b0;
            range_err <= 1'b0;
        end else begin
            done <= go & own;
            if (go) begin
                nan_inf   <= own & (a_special | b_special);
                range_err <= range_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go)
            fp_result <= res_d;
    end

endmodule

`default_nettype wire

// File: alu_int_unit.sv
`timescale 1ns/10ps
`default_nettype none

module alu_int_unit import riscv_isa_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            go,
    input  alu_op_e         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] pc,
    output logic            done,
    output logic [XLEN-1:0] int_result,
    output logic            overflow,
    output logic            bad_addr,
    output logic            branch
);

    logic signed [XLEN:0] sum;               // one bit wider for overflow
    logic [XLEN-1:0]      res_d;
    logic                 ovf_d;
    logic                 bad_d;
    logic                 br_d;
    logic                 lt;
    logic                 own;

    assign lt  = $signed(a) < $signed(b);
    assign own = (op != op_fmul) && (op != op_fclass);  // op_none also completes here

    always_comb begin
        sum   = '0;
        res_d = '0;
        ovf_d = 1'b0;
        bad_d = 1'b0;
        br_d  = 1'b0;
        case (op)
            op_sub: begin
                sum   = {a[XLEN-1], a} - {b[XLEN-1], b};
                res_d = sum[XLEN-1:0];
                ovf_d = sum[XLEN] ^ sum[XLEN-1];    // sign bits disagree
            end
            op_addi: begin
                sum   = {a[XLEN-1], a} + {imm[XLEN-1], imm};
                res_d = sum[XLEN-1:0];
                ovf_d = sum[XLEN] ^ sum[XLEN-1];
            end
            op_addr: begin
                sum   = {a[XLEN-1], a} + {imm[XLEN-1], imm};
                res_d = sum[XLEN-1:0];
                bad_d = (sum < MEM_LO) || (sum > MEM_HI);  // outside data window
            end
            op_beq: begin
                br_d  = (a == b);
                res_d = {{(XLEN-1){1'b0}}, br_d};
            end
            op_blt: begin
                br_d  = lt;
                res_d = {{(XLEN-1){1'b0}}, lt};
            end
            op_jalr:  res_d = pc + XLEN'(4);     // link value
            op_auipc: res_d = pc + imm;          // imm already shifted by the core
            op_slt:   res_d = {{(XLEN-1){1'b0}}, lt};
            op_srl:   res_d = a >> b;            // logical, full shift amount
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done     <= 1'b0;
            overflow <= 1'b0;
            bad_addr <= 1'b0;
            branch   <= 1'b0;
        end else begin
            done <= go & own;
            if (go) begin
                overflow <= ovf_d;
                bad_addr <= bad_d;
                branch   <= br_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go)
            int_result <= res_d;
    end

endmodule

`default_nettype wire

// File: alu_top.sv
`timescale 1ns/10ps
`default_nettype none

module alu_top import riscv_isa_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cyc,
    input  logic            stb,
    input  logic [6:0]      opcode,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    input  logic [XLEN-1:0] r1,
    input  logic [XLEN-1:0] r2,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] pc,
    output logic            ack,
    output logic [XLEN-1:0] result,
    output logic            do_branch,
    output logic            invalid
);

    logic            go;
    alu_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm_q;
    logic [XLEN-1:0] pc_q;
    logic            int_done;
    logic [XLEN-1:0] int_result;
    logic            overflow;
    logic            bad_addr;
    logic            branch;
    logic            fp_done;
    logic [XLEN-1:0] fp_result;
    logic            nan_inf;
    logic            range_err;

    alu_decode u_decode (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .ack(ack),
        .opcode(opcode), .funct3(funct3), .funct7(funct7),
        .r1(r1), .r2(r2), .imm(imm), .pc(pc),
        .go(go), .op(op), .a(a), .b(b), .imm_q(imm_q), .pc_q(pc_q)
    );

    alu_int_unit u_int (
        .clk(clk), .rst_n(rst_n), .go(go), .op(op),
        .a(a), .b(b), .imm(imm_q), .pc(pc_q),
        .done(int_done), .int_result(int_result),
        .overflow(overflow), .bad_addr(bad_addr), .branch(branch)
    );

    alu_fp_unit u_fp (
        .clk(clk), .rst_n(rst_n), .go(go), .op(op), .a(a), .b(b),
        .done(fp_done), .fp_result(fp_result),
        .nan_inf(nan_inf), .range_err(range_err)
    );

    alu_writeback u_writeback (
        .clk(clk), .rst_n(rst_n), .int_done(int_done), .fp_done(fp_done),
        .int_result(int_result), .fp_result(fp_result),
        .overflow(overflow), .bad_addr(bad_addr), .branch(branch),
        .nan_inf(nan_inf), .range_err(range_err),
        .ack(ack), .result(result), .do_branch(do_branch), .invalid(invalid)
    );

endmodule

`default_nettype wire

// File: alu_writeback.sv
`timescale 1ns/10ps
`default_nettype none

module alu_writeback import riscv_isa_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            int_done,
    input  logic            fp_done,
    input  logic [XLEN-1:0] int_result,
    input  logic [XLEN-1:0] fp_result,
    input  logic            overflow,
    input  logic            bad_addr,
    input  logic            branch,
    input  logic            nan_inf,
    input  logic            range_err,
    output logic            ack,
    output logic [XLEN-1:0] result,
    output logic            do_branch,
    output logic            invalid
);

    logic any_done;

    assign any_done = int_done | fp_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack       <= 1'b0;
            do_branch <= 1'b0;
            invalid   <= 1'b0;
        end else begin
            ack <= any_done;                 // done is a pulse, so ack is too
            if (any_done) begin
                do_branch <= branch;
                // the idle unit holds zero flags for this op
                invalid   <= overflow | bad_addr | nan_inf | range_err;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (int_done)
            result <= int_result;
        else if (fp_done)
            result <= fp_result;
    end

endmodule

`default_nettype wire

// File: fp32_pkg.sv
`default_nettype none

package fp32_pkg;

    // field layout of an ieee-754 single: sign, exponent, mantissa
    localparam int EXP_W    = 8;
    localparam int MAN_W    = 23;
    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = 255;           // infinity and nan

    // fclass result bit positions
    localparam int CLS_NEG_INF  = 0;
    localparam int CLS_NEG_NORM = 1;
    localparam int CLS_NEG_SUB  = 2;
    localparam int CLS_NEG_ZERO = 3;
    localparam int CLS_POS_ZERO = 4;
    localparam int CLS_POS_SUB  = 5;
    localparam int CLS_POS_NORM = 6;
    localparam int CLS_POS_INF  = 7;
    localparam int CLS_SNAN     = 8;         // mantissa msb clear
    localparam int CLS_QNAN     = 9;         // mantissa msb set

endpackage

`default_nettype wire

// File: riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

    localparam int XLEN = 32;                // one machine word

    // valid data memory window for load and store addresses
    localparam int MEM_LO = 4096;
    localparam int MEM_HI = 8191;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,                 // register-register integer
        OP_IMM = 7'b0010011,                 // register-immediate integer
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        AUIPC  = 7'b0010111,
        OP_FP  = 7'b1010011                  // single-precision arithmetic
    } opcode_e;

    // one funct3 encoding serves several of the kept instructions
    typedef enum logic [2:0] {
        F3_ADD    = 3'b000,                  // sub, addi, beq, jalr, fmul with rne
        F3_FCLASS = 3'b001,
        F3_SLT    = 3'b010,                  // also the word width of lw and sw
        F3_BLT    = 3'b100,
        F3_SRL    = 3'b101
    } funct3_e;

    typedef enum logic [6:0] {
        F7_BASE   = 7'b0000000,              // slt and srl
        F7_SUB    = 7'b0100000,
        F7_FMUL   = 7'b0001000,
        F7_FCLASS = 7'b1110000
    } funct7_e;

    // operation carried down the pipeline after decode
    typedef enum logic [3:0] {
        op_none,                             // unmatched field combination
        op_sub,
        op_addi,
        op_addr,                             // load and store address
        op_beq,
        op_blt,
        op_jalr,
        op_auipc,
        op_slt,
        op_srl,
        op_fmul,
        op_fclass
    } alu_op_e;

endpackage

`default_nettype wire

// File: sources.f
riscv_isa_pkg.sv
fp32_pkg.sv
alu_decode.sv
alu_int_unit.sv
alu_fp_unit.sv
alu_writeback.sv
alu_top.sv
tb_alu.sv

// File: tb_alu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_alu import riscv_isa_pkg::*, fp32_pkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int NUM_TXN      = 40;
    localparam int CYC_PER_TXN  = 6;                 // drive, accept, three stages, release
    localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_TXN * CYC_PER_TXN;
    localparam int ACK_EDGES    = 3;

    logic            clk;
    logic            rst_n;
    logic            cyc;
    logic            stb;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] r1;
    logic [XLEN-1:0] r2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic            ack;
    logic [XLEN-1:0] result;
    logic            do_branch;
    logic            invalid;

    logic [XLEN-1:0] got_result;                     // response captured while ack is high
    logic            got_branch;
    logic            got_invalid;
    int              mismatch_count;
    int              protocol_count;
    int              cycle_count;
    integer          seed;

    alu_top uut (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb),
        .opcode(opcode), .funct3(funct3), .funct7(funct7),
        .r1(r1), .r2(r2), .imm(imm), .pc(pc),
        .ack(ack), .result(result), .do_branch(do_branch), .invalid(invalid)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_word(input string what, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s result %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_response(input string what, input logic [XLEN-1:0] exp_result,
                                  input logic exp_branch, input logic exp_invalid);
        check_word(what, got_result, exp_result);
        check_flag({what, " do_branch"}, got_branch, exp_branch);
        check_flag({what, " invalid"}, got_invalid, exp_invalid);
    endtask

    // one full wishbone transaction, five rising edges when the DUT behaves
    task automatic issue(input string what, input logic [6:0] opc, input logic [2:0] f3,
                         input logic [6:0] f7, input logic [XLEN-1:0] v1,
                         input logic [XLEN-1:0] v2, input logic [XLEN-1:0] vimm,
                         input logic [XLEN-1:0] vpc);
        int   edges;
        logic seen;
        edges = 1;                                   // the acceptance edge loads decode
        seen  = 1'b0;
        @(posedge clk);
        cyc    <= 1'b1;
        stb    <= 1'b1;
        opcode <= opc;
        funct3 <= f3;
        funct7 <= f7;
        r1     <= v1;
        r2     <= v2;
        imm    <= vimm;
        pc     <= vpc;
        @(posedge clk);                              // request accepted here
        while (!seen && edges < 2 * ACK_EDGES) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            seen = ack;
        end
        got_result  = result;
        got_branch  = do_branch;
        got_invalid = invalid;
        if (!seen) begin
            protocol_count++;
            $display("%s: no ack within %0d edges from acceptance", what, edges);
        end else if (edges != ACK_EDGES) begin
            protocol_count++;
            $display("%s: ack came %0d edges from acceptance instead of %0d",
                     what, edges, ACK_EDGES);
        end
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        @(negedge clk);
        if (ack) begin
            protocol_count++;
            $display("%s: ack stayed high for more than one cycle", what);
        end
    endtask

    task automatic test_handshake();
        @(negedge clk);
        check_flag("ack after reset", ack, 1'b0);
        issue("unmatched opcode", 7'b1111111, 3'b000, 7'b0000000,
              32'h1234_5678, 32'h9abc_def0, 32'h0000_0010, 32'h0000_0100);
        check_response("unmatched opcode", '0, 1'b0, 1'b0);
    endtask

    task automatic test_int_arith();
        logic [XLEN-1:0] va;
        logic [XLEN-1:0] vb;
        logic [XLEN-1:0] exp;
        logic            ovf;
        int              i;
        for (i = 0; i < 3; i++) begin
            va  = $random(seed);
            vb  = $random(seed);
            exp = va - vb;
            ovf = (va[XLEN-1] != vb[XLEN-1]) && (exp[XLEN-1] != va[XLEN-1]);
            issue("sub", OP, F3_ADD, F7_SUB, va, vb, '0, '0);
            check_response("sub", exp, 1'b0, ovf);
        end
        for (i = 0; i < 2; i++) begin
            va  = $random(seed);
            vb  = $random(seed);
            vb  = {{20{vb[11]}}, vb[11:0]};          // 12-bit immediate, sign extended
            exp = va + vb;
            ovf = (va[XLEN-1] == vb[XLEN-1]) && (exp[XLEN-1] != va[XLEN-1]);
            issue("addi", OP_IMM, F3_ADD, F7_BASE, va, '0, vb, '0);
            check_response("addi", exp, 1'b0, ovf);
        end
        issue("addi overflow", OP_IMM, F3_ADD, F7_BASE, 32'h7fff_ffff, '0, 32'h1, '0);
        check_response("addi overflow", 32'h8000_0000, 1'b0, 1'b1);
        for (i = 0; i < 3; i++) begin
            va  = $random(seed);
            vb  = $random(seed);
            exp = ($signed(va) < $signed(vb)) ? 32'd1 : 32'd0;
            issue("slt", OP, F3_SLT, F7_BASE, va, vb, '0, '0);
            check_response("slt", exp, 1'b0, 1'b0);
        end
        for (i = 0; i < 3; i++) begin
            va  = $random(seed);
            vb  = $random(seed);
            vb  = vb & 32'd31;                       // keep the shift inside the word
            exp = va >> vb;
            issue("srl", OP, F3_SRL, F7_BASE, va, vb, '0, '0);
            check_response("srl", exp, 1'b0, 1'b0);
        end
    endtask

    task automatic addr_case(input string what, input logic [6:0] opc,
                             input logic [XLEN-1:0] base, input logic [XLEN-1:0] off,
                             input logic exp_invalid);
        issue(what, opc, F3_SLT, F7_BASE, base, 32'h5a5a_5a5a, off, '0);
        check_response(what, base + off, 1'b0, exp_invalid);
    endtask

    task automatic test_addr_window();
        addr_case("load 4095", LOAD, 32'd4000, 32'd95, 1'b1);
        addr_case("store 4096", STORE, 32'd4352, 32'hffff_ff00, 1'b0);  // offset -256
        addr_case("load 8191", LOAD, 32'd8000, 32'd191, 1'b0);
        addr_case("store 8192", STORE, 32'd8191, 32'd1, 1'b1);
    endtask

    task automatic branch_case(input string what, input logic [2:0] f3,
                               input logic [XLEN-1:0] va, input logic [XLEN-1:0] vb,
                               input logic taken);
        issue(what, BRANCH, f3, F7_BASE, va, vb, 32'h0000_0040, 32'h0000_0800);
        check_response(what, {{(XLEN-1){1'b0}}, taken}, taken, 1'b0);
    endtask

    task automatic test_branch_link();
        branch_case("beq equal", F3_ADD, 32'd5, 32'd5, 1'b1);
        branch_case("beq less", F3_ADD, 32'hffff_fffd, 32'd2, 1'b0);      // -3 and 2
        branch_case("beq greater", F3_ADD, 32'd7, 32'hffff_ffff, 1'b0);   // 7 and -1
        branch_case("blt equal", F3_BLT, 32'd5, 32'd5, 1'b0);
        branch_case("blt less", F3_BLT, 32'hffff_fffd, 32'd2, 1'b1);
        branch_case("blt greater", F3_BLT, 32'd7, 32'hffff_ffff, 1'b0);
        issue("jalr", JALR, F3_ADD, F7_BASE, 32'h0000_2000, '0, '0, 32'h0000_0400);
        check_response("jalr", 32'h0000_0404, 1'b0, 1'b0);
        issue("auipc", AUIPC, 3'b000, F7_BASE, '0, '0, 32'h1234_5000, 32'h0000_1000);
        check_response("auipc", 32'h1234_6000, 1'b0, 1'b0);
    endtask

    task automatic mul_case(input string what, input logic [XLEN-1:0] x,
                            input logic [XLEN-1:0] y, input logic [XLEN-1:0] exp,
                            input logic exp_invalid);
        issue(what, OP_FP, F3_ADD, F7_FMUL, x, y, '0, '0);
        check_response(what, exp, 1'b0, exp_invalid);
    endtask

    task automatic test_fmul();
        mul_case("1.5 x 2.0", 32'h3fc0_0000, 32'h4000_0000, 32'h4040_0000, 1'b0);
        mul_case("-2.5 x 4.0", 32'hc020_0000, 32'h4080_0000, 32'hc120_0000, 1'b0);
        // +0 has exponent field 0, so the range flag is raised
        mul_case("-0 x pi", 32'h8000_0000, 32'h4049_0fdb, 32'h0000_0000, 1'b1);
        mul_case("max normal x 2.0", 32'h7f7f_ffff, 32'h4000_0000, 32'h7f80_0000, 1'b1);
        mul_case("0.5 x min normal", 32'h3f00_0000, 32'h0080_0000, 32'h0000_0000, 1'b1);
    endtask

    task automatic class_case(input string what, input logic [XLEN-1:0] x, input int idx,
                              input logic exp_invalid);
        logic [XLEN-1:0] exp;
        exp      = '0;
        exp[idx] = 1'b1;
        issue(what, OP_FP, F3_FCLASS, F7_FCLASS, x, '0, '0, '0);
        check_response(what, exp, 1'b0, exp_invalid);
    endtask

    task automatic test_fclass();
        class_case("fclass -inf", 32'hff80_0000, CLS_NEG_INF, 1'b1);
        class_case("fclass +inf", 32'h7f80_0000, CLS_POS_INF, 1'b1);
        class_case("fclass qnan", 32'h7fc0_0000, CLS_QNAN, 1'b1);
        class_case("fclass snan", 32'h7f80_0001, CLS_SNAN, 1'b1);
        class_case("fclass -sub", 32'h8000_0001, CLS_NEG_SUB, 1'b0);
        class_case("fclass +sub", 32'h0040_0000, CLS_POS_SUB, 1'b0);
        class_case("fclass -zero", 32'h8000_0000, CLS_NEG_ZERO, 1'b0);
        class_case("fclass +zero", 32'h0000_0000, CLS_POS_ZERO, 1'b0);
        class_case("fclass -norm", 32'hbf80_0000, CLS_NEG_NORM, 1'b0);
        class_case("fclass +norm", 32'h3f80_0000, CLS_POS_NORM, 1'b0);
    endtask

    initial begin
        clk            = 1'b0;
        mismatch_count = 0;
        protocol_count = 0;
        cycle_count    = 0;
        seed           = 66;
        rst_n  <= 1'b0;
        cyc    <= 1'b0;
        stb    <= 1'b0;
        opcode <= '0;
        funct3 <= '0;
        funct7 <= '0;
        r1     <= '0;
        r2     <= '0;
        imm    <= '0;
        pc     <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        test_handshake();
        test_int_arith();
        test_addr_window();
        test_branch_link();
        test_fmul();
        test_fclass();
        $display("error count: %0d value mismatches, %0d protocol errors",
                 mismatch_count, protocol_count);
        if (mismatch_count == 0 && protocol_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
